//--- include/gf3_macros.svh
`ifndef GF3_MACROS_SVH
`define GF3_MACROS_SVH

// base field GF(3^m), reduced by p(x) = x^97 + x^12 + 2
`define GF_M 97

// two bits per trit
`define GF_W (2 * `GF_M)

// trit index of the middle term of p(x)
`define GF_TAP 12

// three trits of the multiplier operand consumed per step
`define GF_DIGITS ((`GF_M + 2) / 3)

// wide enough to hold GF_DIGITS
`define GF_CNT_W 6

`endif

//--- src/gf3_pkg.sv
`include "gf3_macros.svh"

package gf3_pkg;

    // trit i sits at bits 2i+1..2i, codes 00/01/10
    typedef logic [`GF_W-1:0] gf3m_t;

    typedef struct packed {
        gf3m_t c2;
        gf3m_t c1;
        gf3m_t c0;
    } gf33m_t;

    // one phase per karatsuba sub-product, then idle
    typedef enum logic [2:0] {
        PH_A2B2,
        PH_S21,
        PH_A1B1,
        PH_S20,
        PH_S10,
        PH_A0B0,
        PH_DONE
    } phase_e;

    typedef struct packed {
        logic       valid;
        logic [2:0] idx;  // product slot x0..x5
    } prod_wr_t;

    function automatic logic [1:0] trit_add(input logic [1:0] p, input logic [1:0] q);
        logic [2:0] s;
        s = {1'b0, p} + {1'b0, q};
        if (s >= 3'd3)
            s = s - 3'd3;
        return s[1:0];
    endfunction

    function automatic logic [1:0] trit_mul(input logic [1:0] p, input logic [1:0] q);
        logic [1:0] r;
        r[0] = (p == 2'b01 && q == 2'b01) || (p == 2'b10 && q == 2'b10);
        r[1] = (p == 2'b01 && q == 2'b10) || (p == 2'b10 && q == 2'b01);
        return r;
    endfunction

    function automatic logic [1:0] trit_neg(input logic [1:0] p);
        return {p[0], p[1]};  // swaps 1 and 2
    endfunction

    function automatic gf3m_t gf3m_add(input gf3m_t p, input gf3m_t q);
        gf3m_t r;
        for (int i = 0; i < `GF_M; i++)
            r[2*i +: 2] = trit_add(p[2*i +: 2], q[2*i +: 2]);
        return r;
    endfunction

    function automatic gf3m_t gf3m_neg(input gf3m_t p);
        gf3m_t r;
        for (int i = 0; i < `GF_M; i++)
            r[2*i +: 2] = trit_neg(p[2*i +: 2]);
        return r;
    endfunction

endpackage

//--- src/f33m_decode.sv
module f33m_decode (
    input  logic              clk,
    input  logic              reset,
    input  gf3_pkg::gf33m_t   a,
    input  gf3_pkg::gf33m_t   b,
    input  logic              prod_done,
    output gf3_pkg::gf3m_t    op_x,
    output gf3_pkg::gf3m_t    op_y,
    output logic              load,
    output gf3_pkg::prod_wr_t wr,
    output logic              finish
);

    gf3_pkg::phase_e phase;
    logic            kick;  // first load after reset
    gf3_pkg::gf3m_t  sa21, sa20, sa10;
    gf3_pkg::gf3m_t  sb21, sb20, sb10;

    assign sa21 = gf3_pkg::gf3m_add(a.c2, a.c1);
    assign sa20 = gf3_pkg::gf3m_add(a.c2, a.c0);
    assign sa10 = gf3_pkg::gf3m_add(a.c1, a.c0);
    assign sb21 = gf3_pkg::gf3m_add(b.c2, b.c1);
    assign sb20 = gf3_pkg::gf3m_add(b.c2, b.c0);
    assign sb10 = gf3_pkg::gf3m_add(b.c1, b.c0);

    always_comb
    begin
        case (phase)
            gf3_pkg::PH_A2B2:
            begin
                op_x = a.c2;
                op_y = b.c2;
            end
            gf3_pkg::PH_S21:
            begin
                op_x = sa21;
                op_y = sb21;
            end
            gf3_pkg::PH_A1B1:
            begin
                op_x = a.c1;
                op_y = b.c1;
            end
            gf3_pkg::PH_S20:
            begin
                op_x = sa20;
                op_y = sb20;
            end
            gf3_pkg::PH_S10:
            begin
                op_x = sa10;
                op_y = sb10;
            end
            gf3_pkg::PH_A0B0:
            begin
                op_x = a.c0;
                op_y = b.c0;
            end
            default:
            begin
                op_x = '0;
                op_y = '0;
            end
        endcase
    end

    // slot index is the phase that produced it
    assign wr.valid = prod_done;
    assign wr.idx   = phase;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase  <= gf3_pkg::PH_A2B2;
            kick   <= 1'b1;
            load   <= 1'b0;
            finish <= 1'b0;
        end
        else
        begin
            kick   <= 1'b0;
            load   <= kick || (prod_done && phase < gf3_pkg::PH_A0B0);
            finish <= prod_done && phase == gf3_pkg::PH_A0B0;
            if (prod_done && phase != gf3_pkg::PH_DONE)
                phase <= gf3_pkg::phase_e'(phase + 3'd1);
        end
    end

    // a new operand set must never overlap a product strobe
    assert property (@(posedge clk) disable iff (reset) !(load && prod_done));

    assert property (@(posedge clk) disable iff (reset)
        phase == gf3_pkg::PH_DONE |=> phase == gf3_pkg::PH_DONE);

endmodule

//--- src/f3m_mult_serial.sv
`include "gf3_macros.svh"

module f3m_mult_serial (
    input  logic           clk,
    input  logic           reset,
    input  logic           load,
    input  gf3_pkg::gf3m_t op_x,
    input  gf3_pkg::gf3m_t op_y,
    output gf3_pkg::gf3m_t prod,
    output logic           prod_done
);

    localparam int XT = `GF_M + 3;  // trits before reduction
    localparam logic [`GF_CNT_W-1:0] DIGITS = `GF_CNT_W'(`GF_DIGITS);
    localparam gf3_pkg::gf3m_t TRIT_LO = {`GF_M{2'b01}};

    gf3_pkg::gf3m_t       x, y, acc;
    gf3_pkg::gf3m_t       x_red, p_red, acc_next;
    logic [2*XT-1:0]      xsh;  // x * x^3, unreduced
    logic [2*XT-1:0]      pp;   // x * digit, unreduced
    logic [2*XT+3:0]      xz;   // x padded with zero trits
    logic [`GF_CNT_W-1:0] cnt;
    logic                 busy;
    logic                 last;
    logic                 bad_x, bad_y;

    assign xz  = {6'b0, x, 4'b0};
    assign xsh = {x, 6'b0};

    genvar k, i;

    // digit y2 x^2 + y1 x + y0 times x
    for (k = 0; k < XT; k++)
    begin : g_pp
        logic [1:0] t0, t1, t2;
        assign t0 = gf3_pkg::trit_mul(xz[2*(k+2) +: 2], y[1:0]);
        assign t1 = gf3_pkg::trit_mul(xz[2*(k+1) +: 2], y[3:2]);
        assign t2 = gf3_pkg::trit_mul(xz[2*k +: 2], y[5:4]);
        assign pp[2*k +: 2] = gf3_pkg::trit_add(gf3_pkg::trit_add(t0, t1), t2);
    end

    // x^(97+j) = 2 x^(12+j) + x^j
    for (i = 0; i < `GF_M; i++)
    begin : g_fold
        logic [1:0] x_fb, p_fb;
        if (i < 3)
        begin : g_unit
            assign x_fb = xsh[2*(`GF_M+i) +: 2];
            assign p_fb = pp[2*(`GF_M+i) +: 2];
        end
        else if (i >= `GF_TAP && i < `GF_TAP + 3)
        begin : g_tap
            assign x_fb = gf3_pkg::trit_neg(xsh[2*(`GF_M+i-`GF_TAP) +: 2]);
            assign p_fb = gf3_pkg::trit_neg(pp[2*(`GF_M+i-`GF_TAP) +: 2]);
        end
        else
        begin : g_none
            assign x_fb = 2'b00;
            assign p_fb = 2'b00;
        end
        assign x_red[2*i +: 2] = gf3_pkg::trit_add(xsh[2*i +: 2], x_fb);
        assign p_red[2*i +: 2] = gf3_pkg::trit_add(pp[2*i +: 2], p_fb);
    end

    assign acc_next = gf3_pkg::gf3m_add(acc, p_red);
    assign last     = busy && cnt == `GF_CNT_W'(1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            cnt       <= '0;
            prod_done <= 1'b0;
        end
        else if (load)
        begin
            busy      <= 1'b1;
            cnt       <= DIGITS;
            prod_done <= 1'b0;
        end
        else
        begin
            prod_done <= last;
            if (busy)
                cnt <= cnt - `GF_CNT_W'(1);
            if (last)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            x   <= op_x;
            y   <= op_y;
            acc <= '0;
        end
        else if (busy)
        begin
            x   <= x_red;
            y   <= y >> 6;  // next three trits
            acc <= acc_next;
            if (last)
                prod <= acc_next;  // held until next load
        end
    end

    assign bad_x = |(op_x & (op_x >> 1) & TRIT_LO);
    assign bad_y = |(op_y & (op_y >> 1) & TRIT_LO);

    // operands from the sequencer carry only valid trit codes
    assert property (@(posedge clk) disable iff (reset) load |-> !bad_x && !bad_y);

endmodule

//--- src/f33m_result.sv
module f33m_result (
    input  logic              clk,
    input  logic              reset,
    input  gf3_pkg::gf3m_t    prod,
    input  gf3_pkg::prod_wr_t wr,
    input  logic              finish,
    output gf3_pkg::gf33m_t   c,
    output logic              done
);

    gf3_pkg::gf3m_t x_q [6];  // karatsuba sub-products
    gf3_pkg::gf3m_t s02, s25, s05;
    gf3_pkg::gf3m_t d1, d2, d3;
    gf3_pkg::gf3m_t c0, c1, c2;

    always_ff @(posedge clk)
    begin
        if (wr.valid)
            x_q[wr.idx] <= prod;
    end

    assign s02 = gf3_pkg::gf3m_add(x_q[0], x_q[2]);
    assign s25 = gf3_pkg::gf3m_add(x_q[2], x_q[5]);
    assign s05 = gf3_pkg::gf3m_add(x_q[0], x_q[5]);

    // cross terms of the schoolbook product
    assign d3 = gf3_pkg::gf3m_add(x_q[1], gf3_pkg::gf3m_neg(s02));
    assign d1 = gf3_pkg::gf3m_add(x_q[4], gf3_pkg::gf3m_neg(s25));
    assign d2 = gf3_pkg::gf3m_add(gf3_pkg::gf3m_add(x_q[3], x_q[2]),
                                  gf3_pkg::gf3m_neg(s05));

    // fold y^4 and y^3 back with y^3 = y + 1
    assign c0 = gf3_pkg::gf3m_add(x_q[5], d3);
    assign c1 = gf3_pkg::gf3m_add(gf3_pkg::gf3m_add(d1, d3), x_q[0]);
    assign c2 = gf3_pkg::gf3m_add(d2, x_q[0]);

    always_ff @(posedge clk)
    begin
        if (finish)
        begin
            c.c2 <= c2;
            c.c1 <= c1;
            c.c0 <= c0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else if (finish)
            done <= 1'b1;  // sticky until next reset
    end

    // level semantics seen by the testbench
    assert property (@(posedge clk) disable iff (reset) done |=> done);

endmodule

//--- src/f33m_mult_top.sv
module f33m_mult_top (
    input  logic            clk,
    input  logic            reset,
    input  gf3_pkg::gf33m_t a,
    input  gf3_pkg::gf33m_t b,
    output gf3_pkg::gf33m_t c,
    output logic            done
);

    gf3_pkg::gf3m_t    op_x, op_y, prod;
    logic              load, prod_done, finish;
    gf3_pkg::prod_wr_t wr;

    f33m_decode i_decode (
        .clk       (clk),
        .reset     (reset),
        .a         (a),
        .b         (b),
        .prod_done (prod_done),
        .op_x      (op_x),
        .op_y      (op_y),
        .load      (load),
        .wr        (wr),
        .finish    (finish)
    );

    f3m_mult_serial i_exec (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .op_x      (op_x),
        .op_y      (op_y),
        .prod      (prod),
        .prod_done (prod_done)
    );

    f33m_result i_result (
        .clk    (clk),
        .reset  (reset),
        .prod   (prod),
        .wr     (wr),
        .finish (finish),
        .c      (c),
        .done   (done)
    );

endmodule

//--- verif/f33m_checker.sv
`include "gf3_macros.svh"

module f33m_checker (
    input  logic            clk,
    input  logic            reset,
    input  gf3_pkg::gf33m_t a,
    input  gf3_pkg::gf33m_t b,
    input  gf3_pkg::gf33m_t c,
    input  logic            done,
    input  logic            aborting,
    input  logic            report,
    output int              errors,
    output int              checked
);

    logic reset_q  = 1'b1;
    logic done_q   = 1'b0;
    logic reported = 1'b0;
    int   err_cnt  = 0;
    int   chk_cnt  = 0;

    assign errors  = err_cnt;
    assign checked = chk_cnt;

    function automatic gf3_pkg::gf3m_t elem_sum(input gf3_pkg::gf3m_t p,
                                                input gf3_pkg::gf3m_t q);
        gf3_pkg::gf3m_t r;
        int             t;
        for (int i = 0; i < `GF_M; i++)
        begin
            t = (int'(p[2*i +: 2]) + int'(q[2*i +: 2])) % 3;
            r[2*i +: 2] = t[1:0];
        end
        return r;
    endfunction

    // schoolbook product folded from the top with x^97 = 2 x^12 + 1
    function automatic gf3_pkg::gf3m_t elem_product(input gf3_pkg::gf3m_t p,
                                                    input gf3_pkg::gf3m_t q);
        int             acc [2*`GF_M-1];
        gf3_pkg::gf3m_t r;
        int             t;
        for (int i = 0; i < 2*`GF_M-1; i++)
            acc[i] = 0;
        for (int i = 0; i < `GF_M; i++)
            for (int j = 0; j < `GF_M; j++)
                acc[i+j] += int'(p[2*i +: 2]) * int'(q[2*j +: 2]);
        for (int d = 2*`GF_M-2; d >= `GF_M; d--)
        begin
            t = acc[d] % 3;
            acc[d - `GF_M] += t;
            acc[d - `GF_M + `GF_TAP] += 2 * t;
        end
        for (int i = 0; i < `GF_M; i++)
        begin
            t = acc[i] % 3;
            r[2*i +: 2] = t[1:0];
        end
        return r;
    endfunction

    function automatic gf3_pkg::gf33m_t triple_product(input gf3_pkg::gf33m_t p,
                                                       input gf3_pkg::gf33m_t q);
        gf3_pkg::gf3m_t  e0, e1, e2, e3, e4;
        gf3_pkg::gf33m_t r;
        e4 = elem_product(p.c2, q.c2);
        e3 = elem_sum(elem_product(p.c2, q.c1), elem_product(p.c1, q.c2));
        e2 = elem_sum(elem_sum(elem_product(p.c2, q.c0), elem_product(p.c1, q.c1)),
                      elem_product(p.c0, q.c2));
        e1 = elem_sum(elem_product(p.c1, q.c0), elem_product(p.c0, q.c1));
        e0 = elem_product(p.c0, q.c0);
        // y^3 = y + 1 and y^4 = y^2 + y
        r.c2 = elem_sum(e2, e4);
        r.c1 = elem_sum(elem_sum(e1, e3), e4);
        r.c0 = elem_sum(e0, e3);
        return r;
    endfunction

    always @(posedge clk)
    begin : watch
        gf3_pkg::gf33m_t model;
        int              fails;
        fails   = 0;
        reset_q <= reset;
        done_q  <= done;
        if (reset && reset_q && done)
        begin
            $display("%0t: done is still high while reset is held", $time);
            fails++;
        end
        if (!reset && reset_q && done)
        begin
            $display("%0t: done is high in the first cycle after reset", $time);
            fails++;
        end
        if (!reset && !reset_q && done_q && !done)
        begin
            $display("%0t: done fell without a reset", $time);
            fails++;
        end
        if (done && !done_q && aborting)
        begin
            $display("%0t: done rose for an operation that was aborted", $time);
            fails++;
        end
        else if (!reset && done && !done_q)
        begin
            model   = triple_product(a, b);
            chk_cnt <= chk_cnt + 1;
            if (c !== model)
            begin
                $display("error at %0t: c expected %h, got %h", $time, model, c);
                $display("test %0d: failed", chk_cnt + 1);
                fails++;
            end
            else
                $display("test %0d: ok", chk_cnt + 1);
        end
        if (report && !reported)
        begin
            $display("results checked: %0d, errors: %0d", chk_cnt, err_cnt);
            reported <= 1'b1;
        end
        err_cnt <= err_cnt + fails;
    end

endmodule

//--- verif/tb_top.sv
`include "gf3_macros.svh"

module tb_top;

    localparam int NUM_TESTS       = 25;
    localparam int OP_CYCLES       = 6 * (`GF_DIGITS + 2);
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 3 * OP_CYCLES / 2;

    logic            clk;
    logic            reset;
    gf3_pkg::gf33m_t a;
    gf3_pkg::gf33m_t b;
    gf3_pkg::gf33m_t c;
    logic            done;
    logic            aborting;  // current operation will be cut short
    logic            report;
    int              seed;
    int              errors;
    int              checked;
    gf3_pkg::gf33m_t ra, rb;

    f33m_mult_top i_dut (
        .clk   (clk),
        .reset (reset),
        .a     (a),
        .b     (b),
        .c     (c),
        .done  (done)
    );

    f33m_checker i_chk (
        .clk      (clk),
        .reset    (reset),
        .a        (a),
        .b        (b),
        .c        (c),
        .done     (done),
        .aborting (aborting),
        .report   (report),
        .errors   (errors),
        .checked  (checked)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic gf3_pkg::gf3m_t random_element();
        gf3_pkg::gf3m_t r;
        int             v;
        for (int i = 0; i < `GF_M; i++)
        begin
            v = $random(seed) % 3;
            if (v < 0)
                v = v + 3;
            r[2*i +: 2] = v[1:0];  // never 11
        end
        return r;
    endfunction

    function automatic gf3_pkg::gf33m_t random_triple();
        gf3_pkg::gf33m_t r;
        r.c2 = random_element();
        r.c1 = random_element();
        r.c0 = random_element();
        return r;
    endfunction

    // operands change only while reset is high
    task automatic apply_reset(input gf3_pkg::gf33m_t av, input gf3_pkg::gf33m_t bv);
        @(posedge clk);
        reset <= 1'b1;
        a     <= av;
        b     <= bv;
        repeat (8) @(posedge clk);
        reset    <= 1'b0;
        aborting <= 1'b0;
    endtask

    task automatic run_product(input gf3_pkg::gf33m_t av, input gf3_pkg::gf33m_t bv);
        apply_reset(av, bv);
        @(posedge clk);
        while (!done)
            @(posedge clk);
    endtask

    task automatic run_aborted(input gf3_pkg::gf33m_t av, input gf3_pkg::gf33m_t bv);
        apply_reset(av, bv);
        aborting <= 1'b1;
        repeat (OP_CYCLES / 2) @(posedge clk);  // roughly three sub-products in
    endtask

    initial
    begin
        seed     = 32'hcc24_dc7b;
        reset    = 1'b1;
        a        = '0;
        b        = '0;
        aborting = 1'b0;
        report   = 1'b0;

        for (int n = 0; n < 20; n++)
        begin
            ra = random_triple();
            rb = random_triple();
            run_product(ra, rb);
        end

        ra    = random_triple();
        rb    = '0;
        rb.c0 = {{(`GF_W-2){1'b0}}, 2'b01};  // multiplicative identity
        run_product(ra, rb);
        run_product('0, random_triple());
        run_product(random_triple(), '0);

        ra.c2 = {`GF_M{2'b10}};
        ra.c1 = {`GF_M{2'b10}};
        ra.c0 = {`GF_M{2'b10}};
        run_product(ra, ra);

        run_aborted(random_triple(), random_triple());
        run_product(random_triple(), random_triple());

        @(posedge clk);
        report <= 1'b1;
        repeat (2) @(posedge clk);
        if (errors == 0 && checked == NUM_TESTS)
            $display("*** TEST PASSED ***");
        else
        begin
            if (checked != NUM_TESTS)
                $display("%0d of %0d results were checked", checked, NUM_TESTS);
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
src/gf3_pkg.sv
src/f33m_decode.sv
src/f3m_mult_serial.sv
src/f33m_result.sv
src/f33m_mult_top.sv
verif/f33m_checker.sv
verif/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the GF(3^(3m)) multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -j 0 \
    -f list.f --top-module tb_top -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** TEST PASSED ***' "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
